//--- list.f
+incdir+design
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_line_store.sv
design/dcache_miss_fsm.sv
design/dcache.sv
bench/dcache_sva.sv
bench/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_dcache

out="$(./obj_dir/Vtb_dcache 2>&1)" || true
echo "$out"

if grep -qx "=== PASS ===" <<< "$out"; then
	exit 0
fi
exit 1

//--- bench/tb_dcache.sv
// one process drives requests and answers memory; addresses limited to tags 0 to 3
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

	localparam int          TIMEOUT = 40;          // cycles per wait loop
	localparam logic [15:0] SEED    = 16'd63344;

	logic        clk;
	logic        rst_n;
	proc_req_t   req;
	logic        stall;
	logic [31:0] rdata;
	mem_req_t    mem_req;
	line_u       mem_rdata;
	logic        mem_ready;

	logic [15:0] lfsr;
	logic [31:0] ref_mem [128];                    // tag[1:0], index, offset
	line_u       mem_lines [logic [27:0]];         // lines written back so far
	logic        mem_busy;
	logic [1:0]  mem_delay;
	int          wb_count;
	logic [27:0] last_wb_addr;

	dcache i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.stall     (stall),
		.rdata     (rdata),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;   // taps 16,14,13,11
		end
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// untouched memory contents
	function automatic logic [31:0] initial_word(input logic [29:0] wa);
		return {2'b00, wa} ^ 32'hA5A5_0000;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
			input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAILED at %0t: %s, got %0h, expected %0h",
				$time, what, got, exp));
		end
	endtask

	function automatic line_u memory_line(input logic [27:0] la);
		line_u l;
		int    i;
		l = '0;
		if (mem_lines.exists(la)) begin
			l = mem_lines[la];
		end else begin
			for (i = 0; i < 4; i++) begin
				l.word[i] = initial_word({la, 2'(i)});
			end
		end
		return l;
	endfunction

	// evicted line must hold the newest value of every word
	task automatic check_writeback(input logic [27:0] la, input line_u l);
		int i;
		for (i = 0; i < 4; i++) begin
			check_equal(l.word[i], ref_mem[{la[4:0], 2'(i)}],
				$sformatf("write-back word %0d of line %0h", i, la));
		end
	endtask

	// slow memory stepped once per falling edge
	task automatic serve_memory();
		logic [31:0] v;
		mem_ready = 1'b0;
		if (mem_req.read || mem_req.write) begin
			if (!mem_busy) begin
				take_bits(2, v);
				mem_delay = v[1:0];   // 0 to 3 wait cycles
				mem_busy  = 1'b1;
			end
			if (mem_delay == 2'd0) begin
				mem_ready = 1'b1;
				mem_busy  = 1'b0;
				if (mem_req.write) begin
					check_writeback(mem_req.addr, mem_req.wdata);
					mem_lines[mem_req.addr] = mem_req.wdata;
					wb_count++;
					last_wb_addr = mem_req.addr;
				end else begin
					mem_rdata = memory_line(mem_req.addr);
				end
			end else begin
				mem_delay--;
			end
		end
	endtask

	// starts and ends on a falling edge
	task automatic access(input logic rd, input logic wr, input logic [6:0] a,
			input logic [31:0] wd, output logic [31:0] data, output int cycles);
		int n;
		req.read  = rd;
		req.write = wr;
		req.addr  = {23'd0, a};
		req.wdata = wd;
		n = 0;
		serve_memory();
		#1;
		while (stall && n < TIMEOUT) begin
			@(negedge clk);
			serve_memory();
			#1;
			n++;
		end
		if (stall) begin
			stop_with_failure($sformatf("timeout: stall stayed high for %0d cycles at %0t",
				n, $time));
		end
		data   = rdata;
		cycles = n;
		if (wr) begin
			ref_mem[a] = wd;          // commits at the next rising edge
		end
		@(negedge clk);
		req = '0;
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [31:0] v;
		logic [31:0] got;
		logic [31:0] exp;
		logic [6:0]  a;
		logic        wr;
		int          cycles;
		int          k;
		int          wb_before;
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		mem_rdata = '0;
		mem_ready = 1'b0;
		lfsr = SEED;
		mem_busy = 1'b0;
		mem_delay = '0;
		wb_count = 0;
		last_wb_addr = '0;
		for (k = 0; k < 128; k++) begin
			ref_mem[k] = initial_word(30'(k));
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// quiet after reset
		for (k = 0; k < 4; k++) begin
			#1;
			check_equal(stall, 1'b0, "stall with no request");
			check_equal(mem_req.read, 1'b0, "memory read with no request");
			check_equal(mem_req.write, 1'b0, "memory write with no request");
			@(negedge clk);
		end

		// cold read
		access(1'b1, 1'b0, 7'h01, '0, got, cycles);
		check_equal(cycles != 0, 1'b1, "cold read did not stall");
		check_equal(got, initial_word(30'h01), "cold read data");

		// write then read back while resident
		access(1'b0, 1'b1, {2'd0, 3'd1, 2'd2}, 32'h1234_5678, got, cycles);
		access(1'b1, 1'b0, {2'd0, 3'd1, 2'd2}, '0, got, cycles);
		check_equal(cycles, 0, "stall cycles of a resident read");
		check_equal(got, 32'h1234_5678, "read after write");

		// conflict at index 2 evicts the written line
		access(1'b0, 1'b1, {2'd1, 3'd2, 2'd3}, 32'hCAFE_0001, got, cycles);
		wb_before = wb_count;
		access(1'b1, 1'b0, {2'd2, 3'd2, 2'd0}, '0, got, cycles);
		check_equal(wb_count, wb_before + 1, "write-back count on conflict");
		check_equal(last_wb_addr, {25'd1, 3'd2}, "write-back line address");
		check_equal(got, ref_mem[{2'd2, 3'd2, 2'd0}], "conflicting read data");
		access(1'b1, 1'b0, {2'd1, 3'd2, 2'd3}, '0, got, cycles);
		check_equal(got, 32'hCAFE_0001, "evicted word read back");

		// random traffic
		for (k = 0; k < 400; k++) begin
			take_bits(1, v);
			wr = v[0];
			take_bits(7, v);
			a = v[6:0];
			take_bits(32, v);
			exp = ref_mem[a];
			access(!wr, wr, a, v, got, cycles);
			if (!wr) begin
				check_equal(got, exp, $sformatf("random read %0d at %0h", k, a));
			end
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- bench/dcache_sva.sv
// watches the memory side only; strobes are sampled at the rising edge
`timescale 1ns/1ps

module dcache_sva import dcache_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input mem_req_t mem_req,
	input logic     mem_ready
);

	logic strobe;

	assign strobe = mem_req.read | mem_req.write;   // any transaction open

	// ----------------------------------------------------------------------
	// handshake rules
	// ----------------------------------------------------------------------
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req.read && mem_req.write))
		else $error("memory read and write strobes set together");

	// address, data and strobe frozen while memory is not ready
	a_hold_until_ready: assert property (@(posedge clk) disable iff (!rst_n)
		strobe && !mem_ready |=> $stable(mem_req))
		else $error("memory request changed before mem_ready");

	a_quiet_after_reset: assert property (@(posedge clk)
		(!rst_n || $rose(rst_n)) |-> !strobe)
		else $error("memory strobe set in or right after reset");

endmodule

bind dcache dcache_sva i_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.mem_req   (mem_req),
	.mem_ready (mem_ready)
);

//--- design/dcache.sv
// direct-mapped cache with hits in the request cycle; a valid victim is written back whole
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  proc_req_t             req,
	output logic                  stall,
	output logic [`DC_WORD_W-1:0] rdata,
	output mem_req_t              mem_req,
	input  line_u                 mem_rdata,
	input  logic                  mem_ready
);

	logic  hit;
	logic  victim_valid;
	tag_t  victim_tag;
	line_u line;
	logic  word_we;
	logic  refill_we;

	// ----------------------------------------------------------------------
	// stores
	// ----------------------------------------------------------------------
	dcache_tag_store i_tag_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.addr         (req.addr),
		.refill_we    (refill_we),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag)
	);

	dcache_line_store i_line_store (
		.clk          (clk),
		.addr         (req.addr),
		.wdata        (req.wdata),
		.word_we      (word_we),
		.refill_we    (refill_we),
		.refill_line  (mem_rdata),    // straight from memory
		.line         (line),
		.rdata        (rdata)
	);

	// ----------------------------------------------------------------------
	// miss control
	// ----------------------------------------------------------------------
	dcache_miss_fsm i_miss_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (req),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag),
		.line         (line),
		.mem_ready    (mem_ready),
		.stall        (stall),
		.word_we      (word_we),
		.refill_we    (refill_we),
		.mem_req      (mem_req)
	);

endmodule

//--- design/dcache_miss_fsm.sv
// expects req held stable while stall is high; memory request holds until mem_ready
`timescale 1ns/1ps

module dcache_miss_fsm import dcache_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  proc_req_t req,
	input  logic      hit,
	input  logic      victim_valid,
	input  tag_t      victim_tag,
	input  line_u     line,
	input  logic      mem_ready,
	output logic      stall,
	output logic      word_we,
	output logic      refill_we,
	output mem_req_t  mem_req
);

	miss_state_e state;
	miss_state_e state_nxt;
	logic        access;

	assign access = req.read | req.write;

	// ----------------------------------------------------------------------
	// state register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (access && !hit) begin
					// a valid victim must go back to memory first
					state_nxt = victim_valid ? WRITE_BACK : REFILL;
				end
			end
			WRITE_BACK: begin
				if (mem_ready) begin
					state_nxt = REFILL;
				end
			end
			REFILL: begin
				if (mem_ready) begin
					state_nxt = IDLE;   // request retries as a hit
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	assign stall     = access && ((state != IDLE) || !hit);
	assign word_we   = (state == IDLE) && req.write && hit;
	assign refill_we = (state == REFILL) && mem_ready;

	always_comb begin
		mem_req = '0;
		unique case (state)
			WRITE_BACK: begin
				mem_req.write      = 1'b1;
				mem_req.addr.tag   = victim_tag;      // old owner's address
				mem_req.addr.index = req.addr.index;
				mem_req.wdata      = line;
			end
			REFILL: begin
				mem_req.read       = 1'b1;
				mem_req.addr.tag   = req.addr.tag;
				mem_req.addr.index = req.addr.index;
			end
			default: begin
				mem_req = '0;                          // bus quiet in IDLE
			end
		endcase
	end

endmodule

//--- design/dcache_line_store.sv
// data array without reset; refill has priority over a word write to the same line
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_line_store import dcache_pkg::*; (
	input  logic                  clk,
	input  word_addr_t            addr,
	input  logic [`DC_WORD_W-1:0] wdata,
	input  logic                  word_we,
	input  logic                  refill_we,
	input  line_u                 refill_line,
	output line_u                 line,
	output logic [`DC_WORD_W-1:0] rdata
);

	line_u lines [`DC_LINES];

	// ----------------------------------------------------------------------
	// write side
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (refill_we) begin
			lines[addr.index].flat <= refill_line.flat;   // whole line from memory
		end else if (word_we) begin
			lines[addr.index].word[addr.offset] <= wdata;  // hit write
		end
	end

	// ----------------------------------------------------------------------
	// read side
	// ----------------------------------------------------------------------
	// indexed line goes out whole for write-back
	assign line = lines[addr.index];

	// word select for the processor
	assign rdata = line.word[addr.offset];

endmodule

//--- design/dcache_tag_store.sv
// valid bits clear on reset, tags do not; hit and victim are combinational on addr
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tag_store import dcache_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  word_addr_t addr,
	input  logic       refill_we,
	output logic       hit,
	output logic       victim_valid,
	output tag_t       victim_tag
);

	logic [`DC_LINES-1:0] valid;
	tag_t                 tags [`DC_LINES];

	// ----------------------------------------------------------------------
	// state
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;             // every line empty
		end else if (refill_we) begin
			valid[addr.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (refill_we) begin
			tags[addr.index] <= addr.tag;   // new owner of the line
		end
	end

	// ----------------------------------------------------------------------
	// lookup
	// ----------------------------------------------------------------------
	assign victim_valid = valid[addr.index];
	assign victim_tag   = tags[addr.index];   // old tag until refill lands

	// tag compare only counts on a valid line
	assign hit = victim_valid && (victim_tag == addr.tag);

endmodule

//--- design/dcache_pkg.sv
// cache types; word 0 of a line sits in the low bits of the flat memory view
package dcache_pkg;

	`include "dcache_cfg.svh"

	typedef logic [`DC_ADDR_W-`DC_INDEX_W-`DC_OFFSET_W-1:0] tag_t;

	// processor word address split 25/3/2
	typedef struct packed {
		tag_t                   tag;
		logic [`DC_INDEX_W-1:0]  index;
		logic [`DC_OFFSET_W-1:0] offset;
	} word_addr_t;

	// line address on the memory side
	typedef struct packed {
		tag_t                  tag;
		logic [`DC_INDEX_W-1:0] index;
	} line_addr_t;

	// one line seen flat by memory and by word from the processor
	typedef union packed {
		logic [`DC_WORDS*`DC_WORD_W-1:0]          flat;
		logic [`DC_WORDS-1:0][`DC_WORD_W-1:0]     word;
	} line_u;

	typedef struct packed {
		logic                  read;
		logic                  write;
		word_addr_t            addr;
		logic [`DC_WORD_W-1:0] wdata;
	} proc_req_t;

	typedef struct packed {
		logic       read;
		logic       write;
		line_addr_t addr;
		line_u      wdata;
	} mem_req_t;

	// miss handling
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		WRITE_BACK = 2'd1,
		REFILL     = 2'd2
	} miss_state_e;

endpackage

//--- design/dcache_cfg.svh
// cache geometry; tag width is whatever the word address leaves after index and offset
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// ----------------------------------------------------------------------
// word and address widths
// ----------------------------------------------------------------------
`define DC_WORD_W   32          // data word
`define DC_ADDR_W   30          // processor word address

// ----------------------------------------------------------------------
// line geometry
// ----------------------------------------------------------------------
`define DC_INDEX_W  3           // 8 lines
`define DC_OFFSET_W 2           // 4 words per line
`define DC_LINES    (1 << `DC_INDEX_W)
`define DC_WORDS    (1 << `DC_OFFSET_W)

`endif
